/* src/irq_params.svh */
// Width and count macros for the interrupt subsystem
// Included by the package and by any module that sizes a loop

`ifndef IRQ_PARAMS_SVH
`define IRQ_PARAMS_SVH

// Number of level-triggered interrupt lines
`define IRQ_NUM 32

// Bits needed to name one line
`define IRQ_ID_W 5

`endif

/* src/irq_pkg.sv */
// Shared types for the interrupt subsystem
// Modules import this package and take their widths from it

`default_nettype none

`include "irq_params.svh"

package irq_pkg;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  // One bit per interrupt line, also used for the mask
  typedef logic [`IRQ_NUM-1:0] irq_vec_t;

  // Interrupt number
  typedef logic [`IRQ_ID_W-1:0] irq_id_t;

  // Controller FSM
  typedef enum logic [1:0] {
    IDLE,
    IRQ_PENDING,
    IRQ_DONE
  } int_ctrl_state_e;

  ////////////////////////////////////////////////////////////
  // Structs between blocks
  ////////////////////////////////////////////////////////////

  // Arbiter winner, combinational
  typedef struct packed {
    logic    valid;
    irq_id_t id;
  } irq_claim_t;

  // Pending request towards the core side
  typedef struct packed {
    logic    req;
    irq_id_t id;
  } irq_req_t;

  // One-cycle trap strobe with its cause
  typedef struct packed {
    logic    valid;
    irq_id_t id;
  } trap_t;

endpackage

`default_nettype wire

/* src/irq_arbiter.sv */
// Mask register and fixed-priority pick over the interrupt lines
// Lowest-numbered unmasked active line wins, no clock cycle spent

`timescale 1ns/1ns
`default_nettype none

`include "irq_params.svh"

module irq_arbiter (
  input  logic                clk,
  input  logic                rst_n,
  // Raw level-triggered lines
  input  irq_pkg::irq_vec_t   irq_i,
  // Mask write port, a set bit enables the line
  input  logic                mask_we_i,
  input  irq_pkg::irq_vec_t   mask_i,
  // Winner towards the controller
  output irq_pkg::irq_claim_t claim_o
);

  import irq_pkg::*;

  irq_vec_t mask_q;
  irq_vec_t live;
  irq_id_t  win_id;

  ////////////////////////////////////////////////////////////
  // Mask register
  ////////////////////////////////////////////////////////////

  // All lines masked out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mask_q <= '0;
    end else if (mask_we_i) begin
      mask_q <= mask_i;
    end
  end

  // Lines that survive the mask
  assign live = irq_i & mask_q;

  ////////////////////////////////////////////////////////////
  // Priority pick
  ////////////////////////////////////////////////////////////

  // Walk from the top down so the lowest index is written last
  always_comb begin
    win_id = '0;
    for (int i = `IRQ_NUM - 1; i >= 0; i--) begin
      if (live[i]) begin
        win_id = irq_id_t'(i);
      end
    end
  end

  // Any survivor makes a valid claim
  assign claim_o.valid = |live;
  assign claim_o.id    = win_id;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Winner must be a line the mask lets through
  a_claim_unmasked : assert property (
    @(posedge clk) disable iff (!rst_n)
    claim_o.valid |-> mask_q[claim_o.id]
  ) else $error("claim on masked line %0d", claim_o.id);

endmodule

`default_nettype wire

/* src/int_controller.sv */
// Interrupt controller FSM between the arbiter and the core side
// Captures a claim while enabled, holds it until acked or killed

`timescale 1ns/1ns
`default_nettype none

module int_controller (
  input  logic                clk,
  input  logic                rst_n,
  // Winner from the arbiter
  input  irq_pkg::irq_claim_t claim_i,
  // Global machine interrupt enable
  input  logic                mie_i,
  // Core-side strobes
  input  logic                ack_i,
  input  logic                kill_i,
  // Pending request towards the core side
  output irq_pkg::irq_req_t   req_o
);

  import irq_pkg::*;

  int_ctrl_state_e state_q, state_d;
  irq_id_t         id_q, id_d;

  ////////////////////////////////////////////////////////////
  // State and captured id
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      id_q    <= '0;
    end else begin
      state_q <= state_d;
      id_q    <= id_d;
    end
  end

  always_comb begin
    state_d = state_q;
    id_d    = id_q;
    case (state_q)
      // Take a claim only when enabled
      IDLE: begin
        if (claim_i.valid && mie_i) begin
          state_d = IRQ_PENDING;
          id_d    = claim_i.id;
        end
      end
      // Id frozen, wait for the core side
      IRQ_PENDING: begin
        if (ack_i) begin
          state_d = IRQ_DONE;
        end else if (kill_i) begin
          state_d = IDLE;
        end
      end
      // One dead cycle after the trap is taken
      IRQ_DONE: state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  assign req_o.req = (state_q == IRQ_PENDING);
  assign req_o.id  = id_q;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Waiting request keeps its id, so stall never swaps the winner
  a_id_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (req_o.req && !ack_i && !kill_i) |=> (req_o.req && $stable(req_o.id))
  ) else $error("pending id changed while waiting");

  // Core side never accepts and drops at once
  a_ack_kill_excl : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ack_i && kill_i)
  ) else $error("ack and kill high together");

endmodule

`default_nettype wire

/* src/trap_sequencer.sv */
// Core-side trap entry model for machine-mode interrupts
// Owns mie and mpie, answers the controller, and strobes the trap

`timescale 1ns/1ns
`default_nettype none

module trap_sequencer (
  input  logic              clk,
  input  logic              rst_n,
  // Pending request from the controller
  input  irq_pkg::irq_req_t req_i,
  // Pipeline conditions
  input  logic              stall_i,
  input  logic              flush_i,
  input  logic              mret_i,
  // CSR write of the enable bit
  input  logic              csr_mie_we_i,
  input  logic              csr_mie_i,
  // Strobes back to the controller
  output logic              ack_o,
  output logic              kill_o,
  // Global enable
  output logic              mie_o,
  // Trap strobe and cause
  output irq_pkg::trap_t    trap_o
);

  import irq_pkg::*;

  logic  mie_q;
  logic  mpie_q;
  trap_t trap_q;

  ////////////////////////////////////////////////////////////
  // Accept or drop
  ////////////////////////////////////////////////////////////

  // Flush drops the request, stall only holds it
  assign ack_o  = req_i.req && !flush_i && !stall_i;
  assign kill_o = req_i.req && flush_i;

  ////////////////////////////////////////////////////////////
  // Enable and saved enable
  ////////////////////////////////////////////////////////////

  // CSR write first, then mret, then trap entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q  <= 1'b0;
      mpie_q <= 1'b0;
    end else if (csr_mie_we_i) begin
      mie_q <= csr_mie_i;
    end else if (mret_i) begin
      mie_q <= mpie_q;
    end else if (ack_o) begin
      // Save and close on entry
      mpie_q <= mie_q;
      mie_q  <= 1'b0;
    end
  end

  assign mie_o = mie_q;

  ////////////////////////////////////////////////////////////
  // Trap strobe
  ////////////////////////////////////////////////////////////

  // Valid only for the cycle after the ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trap_q <= '0;
    end else begin
      trap_q.valid <= ack_o;
      trap_q.id    <= req_i.id;
    end
  end

  assign trap_o = trap_q;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Trap runs with interrupts closed
  a_trap_mie_low : assert property (
    @(posedge clk) disable iff (!rst_n)
    trap_o.valid |-> !mie_o
  ) else $error("trap taken with mie still set");

endmodule

`default_nettype wire

/* src/irq_subsys_top.sv */
// Top of the interrupt subsystem
// Arbiter feeds the controller, the trap sequencer answers it

`timescale 1ns/1ns
`default_nettype none

module irq_subsys_top (
  input  logic              clk,
  input  logic              rst_n,
  // Interrupt lines and mask write
  input  irq_pkg::irq_vec_t irq_i,
  input  logic              mask_we_i,
  input  irq_pkg::irq_vec_t mask_i,
  // Pipeline conditions
  input  logic              stall_i,
  input  logic              flush_i,
  input  logic              mret_i,
  // CSR enable write
  input  logic              csr_mie_we_i,
  input  logic              csr_mie_i,
  // Trap strobe and enable state
  output irq_pkg::trap_t    trap_o,
  output logic              mie_o
);

  import irq_pkg::*;

  irq_claim_t claim;
  irq_req_t   req;
  logic       ack;
  logic       kill;

  // Line selection and mask
  irq_arbiter u_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .irq_i     (irq_i),
    .mask_we_i (mask_we_i),
    .mask_i    (mask_i),
    .claim_o   (claim)
  );

  // Pending request FSM, enable read back from the sequencer
  int_controller u_int_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .claim_i (claim),
    .mie_i   (mie_o),
    .ack_i   (ack),
    .kill_i  (kill),
    .req_o   (req)
  );

  // Core-side trap entry
  trap_sequencer u_trap_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .mret_i       (mret_i),
    .csr_mie_we_i (csr_mie_we_i),
    .csr_mie_i    (csr_mie_i),
    .ack_o        (ack),
    .kill_o       (kill),
    .mie_o        (mie_o),
    .trap_o       (trap_o)
  );

endmodule

`default_nettype wire

/* tests/tb_irq_subsys.sv */
// Testbench for the interrupt subsystem top level
// Replays per-cycle records from tests/irq_tests.mem and checks the trap outputs

`timescale 1ns/1ns
`default_nettype none

module tb_irq_subsys;

  import irq_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_REC      = 64;
  localparam int MAX_GAP      = 3;
  localparam int MARGIN       = 20;
  localparam int SEED         = 33;

  // One cycle of stimulus and expected outputs, one hex digit per flag
  typedef struct packed {
    irq_vec_t   irq;
    irq_vec_t   mask;
    logic [3:0] mask_we;
    logic [3:0] stall;
    logic [3:0] flush;
    logic [3:0] mret;
    logic [3:0] csr_we;
    logic [3:0] csr_mie;
    logic [3:0] gap;
    logic [3:0] exp_valid;
    logic [7:0] exp_id;
    logic [3:0] exp_mie;
  } vec_rec_t;

  logic           clk;
  logic           rst_n;
  irq_vec_t       irq_i;
  logic           mask_we_i;
  irq_vec_t       mask_i;
  logic           stall_i;
  logic           flush_i;
  logic           mret_i;
  logic           csr_mie_we_i;
  logic           csr_mie_i;
  trap_t          trap_o;
  logic           mie_o;

  logic [107:0]   recs [MAX_REC];
  int             n_rec;
  logic           loaded;

  irq_subsys_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .irq_i        (irq_i),
    .mask_we_i    (mask_we_i),
    .mask_i       (mask_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .mret_i       (mret_i),
    .csr_mie_we_i (csr_mie_we_i),
    .csr_mie_i    (csr_mie_i),
    .trap_o       (trap_o),
    .mie_o        (mie_o)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Drive and compare
  ////////////////////////////////////////////////////////////

  task automatic apply_record(input vec_rec_t r);
    irq_i        = r.irq;
    mask_we_i    = r.mask_we[0];
    mask_i       = r.mask;
    stall_i      = r.stall[0];
    flush_i      = r.flush[0];
    mret_i       = r.mret[0];
    csr_mie_we_i = r.csr_we[0];
    csr_mie_i    = r.csr_mie[0];
  endtask

  // Quiet bus, no lines and no pipeline events
  task automatic drive_idle();
    irq_i        = '0;
    mask_we_i    = 1'b0;
    mask_i       = '0;
    stall_i      = 1'b0;
    flush_i      = 1'b0;
    mret_i       = 1'b0;
    csr_mie_we_i = 1'b0;
    csr_mie_i    = 1'b0;
  endtask

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  // Id only matters while the strobe is up
  task automatic check_trap(input int idx, input trap_t got, input trap_t exp);
    if (got.valid !== exp.valid) begin
      $display("MISMATCH trap_o.valid at record %0d: got %h expected %h",
               idx, got.valid, exp.valid);
      stop_on_error();
    end
    if (exp.valid && (got.id !== exp.id)) begin
      $display("MISMATCH trap_o.id at record %0d: got %h expected %h",
               idx, got.id, exp.id);
      stop_on_error();
    end
  endtask

  task automatic check_mie(input int idx, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH mie_o at record %0d: got %h expected %h", idx, got, exp);
      stop_on_error();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    vec_rec_t r;
    trap_t    exp_trap;
    logic     last_mie;
    int       gap;
    void'($urandom(SEED));
    rst_n     = 1'b0;
    n_rec     = 0;
    loaded    = 1'b0;
    last_mie  = 1'b0;
    drive_idle();
    // End marker has the mask_we digit at f, low bits tagged with its slot
    for (int k = 0; k < MAX_REC; k++) begin
      recs[k] = {{76{1'b1}}, 32'(k)};
    end
    $readmemh("tests/irq_tests.mem", recs);
    r = recs[0];
    while (n_rec < MAX_REC && r.mask_we != 4'hf) begin
      n_rec++;
      if (n_rec < MAX_REC) begin
        r = recs[n_rec];
      end
    end
    loaded = 1'b1;
    if (n_rec == 0) begin
      $display("No stimulus records could be read from the data file");
      stop_on_error();
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < n_rec; i++) begin
      r = recs[i];
      apply_record(r);
      @(negedge clk);
      exp_trap.valid = r.exp_valid[0];
      exp_trap.id    = irq_id_t'(r.exp_id);
      check_trap(i, trap_o, exp_trap);
      check_mie(i, mie_o, r.exp_mie[0]);
      last_mie = r.exp_mie[0];
      // Idle gap between groups, nothing pending so nothing may trap
      if (r.gap[0]) begin
        gap = $urandom_range(MAX_GAP, 1);
        drive_idle();
        repeat (gap) begin
          @(negedge clk);
          check_trap(i, trap_o, '0);
          check_mie(i, mie_o, last_mie);
        end
      end
    end
    $display("Test completed successfully");
    $finish;
  end

  // Watchdog sized from the record count and the longest gaps
  initial begin
    wait (loaded);
    #((n_rec * (MAX_GAP + 1) + RESET_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Timeout: the run did not finish within its time limit");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* tests/irq_tests.mem */
// irq_i _ mask_i _ mask_we stall flush mret csr_we csr_mie gap _ exp valid _ exp id _ exp mie
// One record per cycle, expected values are the outputs after that cycle's rising edge
// Reset, mask all zero
0000000f_00000000_0_0_0_0_0_0_0_0_00_0
ffffffff_00000000_0_0_0_0_0_0_0_0_00_0
ffffffff_00000000_0_0_0_0_1_1_0_0_00_1
ffffffff_00000000_0_0_0_0_0_0_0_0_00_1
ffffffff_00000000_0_0_0_0_1_0_1_0_00_0
// Basic trap on line 4
00000000_00000010_1_0_0_0_1_1_0_0_00_1
00000010_00000000_0_0_0_0_0_0_0_0_00_1
00000010_00000000_0_0_0_0_0_0_0_1_04_0
00000010_00000000_0_0_0_0_0_0_0_0_00_0
00000010_00000000_0_0_0_0_0_0_1_0_00_0
// Priority, line 1 masked, line 3 wins
00000000_000000a8_1_0_0_0_1_1_0_0_00_1
000000aa_00000000_0_0_0_0_0_0_0_0_00_1
000000aa_00000000_0_0_0_0_0_0_0_1_03_0
000000aa_00000000_0_0_0_0_0_0_1_0_00_0
// Stall holds id 7 while line 3 rises
00000000_00000000_0_0_0_0_1_1_0_0_00_1
00000080_00000000_0_1_0_0_0_0_0_0_00_1
00000088_00000000_0_1_0_0_0_0_0_0_00_1
00000088_00000000_0_1_0_0_0_0_0_0_00_1
00000088_00000000_0_0_0_0_0_0_0_1_07_0
00000088_00000000_0_0_0_0_0_0_1_0_00_0
// Flush kills, line 5 captured again
00000000_00000000_0_0_0_0_1_1_0_0_00_1
00000020_00000000_0_0_0_0_0_0_0_0_00_1
00000020_00000000_0_0_1_0_0_0_0_0_00_1
00000020_00000000_0_0_0_0_0_0_0_0_00_1
00000020_00000000_0_0_0_0_0_0_0_1_05_0
00000020_00000000_0_0_0_0_0_0_1_0_00_0
// Mret restores mie, CSR write beats mret
00000020_00000000_0_0_0_1_0_0_0_0_00_1
00000020_00000000_0_0_0_0_0_0_0_0_00_1
00000020_00000000_0_0_0_0_0_0_0_1_05_0
00000020_00000000_0_0_0_1_1_0_0_0_00_0
00000020_00000000_0_0_0_0_0_0_0_0_00_0
00000020_00000000_0_0_0_1_0_0_0_0_00_1
00000020_00000000_0_0_0_0_0_0_0_0_00_1
00000020_00000000_0_0_0_0_0_0_0_1_05_0
00000000_00000000_0_0_0_0_0_0_0_0_00_0

/* sources.f */
+incdir+src
src/irq_pkg.sv
src/irq_arbiter.sv
src/int_controller.sv
src/trap_sequencer.sv
src/irq_subsys_top.sv
tests/tb_irq_subsys.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP      = tb_irq_subsys
FILELIST = sources.f
OBJ_DIR  = obj_dir
PASS_MSG = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
